/* common/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath width for operands, results and PCs
`define OPERAND_WIDTH 32

// Control stage PC after reset
`define RESET_PC 32'h00000100

// PC shown in the control stage once a flush completes
`define EXC_VECTOR 32'h00000200

// Data memory word address bits, 64 words
`define DMEM_AW 6

// Cycles a MUL spends in execute
`define MUL_CYCLES 4

`endif

/* common/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

   // Operand, result or PC
   typedef logic [`OPERAND_WIDTH-1:0] word_t;

   // Word index into the data memory
   typedef logic [`DMEM_AW-1:0] mem_addr_t;

   // Execute opcodes
   // All 16 codes are taken, illegal insns come in on their own input
   typedef enum logic [3:0] {
      NOP   = 4'd0,
      ADD   = 4'd1,
      SUB   = 4'd2,
      AND   = 4'd3,
      OR    = 4'd4,
      XOR   = 4'd5,
      SHL   = 4'd6,
      SFEQ  = 4'd7,
      SFNE  = 4'd8,
      MUL   = 4'd9,
      LOAD  = 4'd10,
      STORE = 4'd11,
      JR    = 4'd12,
      MFSPR = 4'd13,
      SYS   = 4'd14,
      TRAP  = 4'd15
   } opcode_e;

   // Exception controller states
   typedef enum logic [1:0] {
      RUN   = 2'd0,
      FLUSH = 2'd1
   } exc_state_e;

endpackage

/* common/ctrl_stage_if.sv */
`timescale 1ns/10ps

interface ctrl_stage_if
   import exec_pkg::*;
   ();

   // Exception bits captured with the instruction
   logic    ibus_err;
   logic    ibus_align;
   logic    illegal;
   logic    syscall;
   logic    dbus;
   logic    align;
   logic    trap;

   // PC and opcode of the insn now in the control stage
   word_t   pc_ctrl;
   opcode_e opc;

   // Compare result waiting to update the flag
   logic    flag_set;
   logic    flag_clear;

   // Execute control writes the stage registers
   modport src (
      output ibus_err, ibus_align, illegal, syscall, dbus, align, trap,
      output pc_ctrl, opc, flag_set, flag_clear
   );

   // Exception controller only looks at them
   modport dst (
      input ibus_err, ibus_align, illegal, syscall, dbus, align, trap,
      input pc_ctrl, opc, flag_set, flag_clear
   );

endinterface

/* execute/execute_alu.sv */
`timescale 1ns/10ps

`include "exec_params.svh"

module execute_alu
   import exec_pkg::*;
   (
   input  logic    clk,
   input  logic    rst,
   input  logic    padv_i,
   input  opcode_e opc_i,
   input  word_t   op_a_i,
   input  word_t   op_b_i,
   output logic    alu_valid_o,
   output word_t   result_o,
   output logic    flag_set_o,
   output logic    flag_clear_o
   );

   localparam int CNT_W = $clog2(`MUL_CYCLES);

   logic [CNT_W-1:0] mul_cnt;
   logic             mul_done;
   word_t            mul_prod;
   logic             op_eq;

   assign op_eq = (op_a_i == op_b_i);

   // Multiply sequencer
   // Product lands at the end of cycle MUL_CYCLES-1, valid in the last cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         mul_cnt  <= '0;
         mul_done <= 1'b0;
      end else if (padv_i) begin
         // Insn leaves execute, get ready for the next one
         mul_cnt  <= '0;
         mul_done <= 1'b0;
      end else if ((opc_i == MUL) && !mul_done) begin
         if (mul_cnt == CNT_W'(`MUL_CYCLES - 2)) begin
            mul_done <= 1'b1;
            mul_cnt  <= '0;
         end else begin
            mul_cnt <= mul_cnt + 1'b1;
         end
      end
   end

   // Product register, loaded once per multiply
   always_ff @(posedge clk) begin
      if ((opc_i == MUL) && !mul_done && (mul_cnt == CNT_W'(`MUL_CYCLES - 2)))
         mul_prod <= op_a_i * op_b_i;
   end

   // Only MUL takes more than one cycle
   assign alu_valid_o = (opc_i != MUL) || mul_done;

   // Single cycle results
   always_comb begin
      case (opc_i)
         ADD:     result_o = op_a_i + op_b_i;
         SUB:     result_o = op_a_i - op_b_i;
         AND:     result_o = op_a_i & op_b_i;
         OR:      result_o = op_a_i | op_b_i;
         XOR:     result_o = op_a_i ^ op_b_i;
         SHL:     result_o = op_a_i << op_b_i[4:0];
         MUL:     result_o = mul_prod;
         default: result_o = '0;
      endcase
   end

   // Compare insns set or clear the flag
   assign flag_set_o   = ((opc_i == SFEQ) && op_eq) || ((opc_i == SFNE) && !op_eq);
   assign flag_clear_o = ((opc_i == SFEQ) && !op_eq) || ((opc_i == SFNE) && op_eq);

endmodule

/* execute/execute_lsu.sv */
`timescale 1ns/10ps

`include "exec_params.svh"

module execute_lsu
   import exec_pkg::*;
   (
   input  logic  clk,
   input  logic  rst,
   input  logic  padv_i,
   input  logic  load_i,
   input  logic  store_i,
   input  word_t addr_i,
   input  word_t wdata_i,
   output logic  lsu_valid_o,
   output word_t rdata_o,
   output logic  except_dbus_o,
   output logic  except_align_o
   );

   localparam int    MEM_WORDS = 1 << `DMEM_AW;
   localparam word_t MEM_BYTES = word_t'(MEM_WORDS) << 2;

   word_t     mem [MEM_WORDS];
   mem_addr_t word_idx;
   logic      access;
   logic      pend;
   logic      addr_bad;

   assign access   = load_i || store_i;
   assign word_idx = addr_i[`DMEM_AW+1:2];

   // Address checks, only meaningful for a load or store
   assign except_align_o = access && (addr_i[1:0] != 2'b00);
   assign except_dbus_o  = access && (addr_i >= MEM_BYTES);
   assign addr_bad       = except_align_o || except_dbus_o;

   // One wait cycle before each access is done
   always_ff @(posedge clk) begin
      if (rst)
         pend <= 1'b0;
      else if (padv_i)
         pend <= 1'b0;
      else if (access)
         pend <= 1'b1;
   end

   assign lsu_valid_o = pend;

   // Memory array, store happens as the insn leaves execute
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= '0;
      end else if (store_i && pend && padv_i && !addr_bad) begin
         mem[word_idx] <= wdata_i;
      end
   end

   // Registered read in the wait cycle
   always_ff @(posedge clk) begin
      if (load_i && !pend)
         rdata_o <= mem[word_idx];
   end

endmodule

/* execute/execute_ctrl.sv */
`timescale 1ns/10ps

`include "exec_params.svh"

module execute_ctrl
   import exec_pkg::*;
   (
   input  logic       clk,
   input  logic       rst,
   input  logic       padv_i,
   input  logic       pipeline_flush_i,
   input  opcode_e    opc_i,
   input  word_t      op_b_i,
   input  word_t      pc_i,
   input  word_t      alu_result_i,
   input  word_t      lsu_rdata_i,
   input  logic       alu_valid_i,
   input  logic       lsu_valid_i,
   input  logic       flag_set_i,
   input  logic       flag_clear_i,
   input  logic       ibus_err_i,
   input  logic       illegal_i,
   input  logic       lsu_except_dbus_i,
   input  logic       lsu_except_align_i,
   input  logic       rf_wb_i,
   input  logic       mfspr_we_i,
   input  word_t      epcr_i,
   output logic       execute_valid_o,
   output logic       rf_we_o,
   output word_t      wb_data_o,
   output word_t      ctrl_result_o,
   output word_t      ctrl_rfb_o,
   ctrl_stage_if.src  ctrl
   );

   logic op_alu;
   logic op_lsu;
   logic op_mfspr;
   logic lsu_fault;
   logic ibus_align;

   assign op_alu   = opc_i inside {ADD, SUB, AND, OR, XOR, SHL, SFEQ, SFNE, MUL};
   assign op_lsu   = (opc_i == LOAD) || (opc_i == STORE);
   assign op_mfspr = (opc_i == MFSPR);

   // Stage is done when the unit the insn needs says so
   // Everything else finishes in one cycle
   assign execute_valid_o = op_lsu ? lsu_valid_i :
                            op_alu ? alu_valid_i :
                            1'b1;

   assign lsu_fault = op_lsu && (lsu_except_dbus_i || lsu_except_align_i);

   // Writeback as the insn advances, faulting loads and stores never write
   // MFSPR waits for the exception controller
   assign rf_we_o = (rf_wb_i && padv_i && !op_mfspr && !lsu_fault) ||
                    (op_mfspr && mfspr_we_i);

   // Writeback source
   assign wb_data_o = op_mfspr         ? epcr_i :
                      (opc_i == LOAD)  ? lsu_rdata_i :
                      alu_result_i;

   // Register jump target must be word aligned
   assign ibus_align = (opc_i == JR) && (op_b_i[1:0] != 2'b00);

   // Exception bits, a flush wipes them
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         ctrl.ibus_err   <= 1'b0;
         ctrl.ibus_align <= 1'b0;
         ctrl.illegal    <= 1'b0;
         ctrl.syscall    <= 1'b0;
         ctrl.dbus       <= 1'b0;
         ctrl.align      <= 1'b0;
         ctrl.trap       <= 1'b0;
      end else if (padv_i) begin
         ctrl.ibus_err   <= ibus_err_i;
         ctrl.ibus_align <= ibus_align;
         ctrl.illegal    <= illegal_i;
         ctrl.syscall    <= (opc_i == SYS);
         ctrl.dbus       <= lsu_except_dbus_i;
         ctrl.align      <= lsu_except_align_i;
         ctrl.trap       <= (opc_i == TRAP);
      end
   end

   // Result of the insn, not needed before it is accepted
   always_ff @(posedge clk) begin
      if (padv_i)
         ctrl_result_o <= wb_data_o;
   end

   // B operand, opcode and flag update
   // Flushed insns must not touch the flag either
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         ctrl_rfb_o      <= '0;
         ctrl.opc        <= NOP;
         ctrl.flag_set   <= 1'b0;
         ctrl.flag_clear <= 1'b0;
      end else if (padv_i) begin
         ctrl_rfb_o      <= op_b_i;
         ctrl.opc        <= opc_i;
         ctrl.flag_set   <= flag_set_i;
         ctrl.flag_clear <= flag_clear_i;
      end
   end

   // Control stage PC, shows the vector once a flush is done
   always_ff @(posedge clk) begin
      if (rst)
         ctrl.pc_ctrl <= `RESET_PC;
      else if (pipeline_flush_i)
         ctrl.pc_ctrl <= `EXC_VECTOR;
      else if (padv_i)
         ctrl.pc_ctrl <= pc_i;
   end

endmodule

/* hdl/except_ctrl.sv */
`timescale 1ns/10ps

module except_ctrl
   import exec_pkg::*;
   (
   input  logic      clk,
   input  logic      rst,
   input  logic      stall_i,
   input  logic      execute_valid_i,
   input  opcode_e   opc_i,
   ctrl_stage_if.dst ctrl,
   output logic      padv_o,
   output logic      pipeline_flush_o,
   output logic      mfspr_we_o,
   output word_t     epcr_o,
   output logic      except_o,
   output logic      ctrl_flag_o
   );

   exc_state_e state_q;
   exc_state_e state_d;
   logic       flag_q;

   // Any exception sitting in the control stage
   assign except_o = ctrl.ibus_err | ctrl.ibus_align | ctrl.illegal | ctrl.syscall |
                     ctrl.dbus | ctrl.align | ctrl.trap;

   // Nothing advances while an exception is pending or being flushed
   assign padv_o = execute_valid_i && !stall_i && !except_o && (state_q == RUN);

   assign pipeline_flush_o = (state_q == FLUSH);

   // MFSPR writes the register file as it leaves execute
   assign mfspr_we_o = padv_o && (opc_i == MFSPR);

   always_comb begin
      state_d = state_q;
      case (state_q)
         RUN:     if (except_o) state_d = FLUSH;
         FLUSH:   state_d = RUN;
         default: state_d = RUN;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state_q <= RUN;
      else
         state_q <= state_d;
   end

   // Faulting PC captured on the edge that starts the flush
   always_ff @(posedge clk) begin
      if (rst)
         epcr_o <= '0;
      else if ((state_q == RUN) && except_o)
         epcr_o <= ctrl.pc_ctrl;
   end

   // Architectural flag, compare results show up with the control stage
   always_comb begin
      ctrl_flag_o = flag_q;
      if (ctrl.flag_set && !except_o)
         ctrl_flag_o = 1'b1;
      else if (ctrl.flag_clear && !except_o)
         ctrl_flag_o = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (rst)
         flag_q <= 1'b0;
      else
         flag_q <= ctrl_flag_o;
   end

endmodule

/* hdl/exec_stage_top.sv */
`timescale 1ns/10ps

module exec_stage_top
   import exec_pkg::*;
   (
   input  logic    clk,
   input  logic    rst,
   input  logic    stall_i,
   input  opcode_e opc_i,
   input  word_t   op_a_i,
   input  word_t   op_b_i,
   input  word_t   pc_i,
   input  logic    ibus_err_i,
   input  logic    illegal_i,
   input  logic    rf_wb_i,
   output logic    padv_o,
   output logic    rf_we_o,
   output word_t   wb_data_o,
   output word_t   ctrl_result_o,
   output word_t   ctrl_rfb_o,
   output word_t   ctrl_pc_o,
   output opcode_e ctrl_opc_o,
   output logic    ctrl_flag_o,
   output logic    except_o,
   output logic    flush_o,
   output word_t   epcr_o
   );

   logic  execute_valid;
   logic  mfspr_we;
   logic  alu_valid;
   word_t alu_result;
   logic  alu_flag_set;
   logic  alu_flag_clear;
   logic  lsu_load;
   logic  lsu_store;
   logic  lsu_valid;
   word_t lsu_rdata;
   logic  lsu_dbus;
   logic  lsu_align;

   // Control stage registers between execute control and exception control
   ctrl_stage_if ctrl_if ();

   assign lsu_load   = (opc_i == LOAD);
   assign lsu_store  = (opc_i == STORE);
   assign ctrl_pc_o  = ctrl_if.pc_ctrl;
   assign ctrl_opc_o = ctrl_if.opc;

   execute_alu i_execute_alu (
      .clk          (clk),
      .rst          (rst),
      .padv_i       (padv_o),
      .opc_i        (opc_i),
      .op_a_i       (op_a_i),
      .op_b_i       (op_b_i),
      .alu_valid_o  (alu_valid),
      .result_o     (alu_result),
      .flag_set_o   (alu_flag_set),
      .flag_clear_o (alu_flag_clear)
   );

   // Address comes from operand A, store data from operand B
   execute_lsu i_execute_lsu (
      .clk            (clk),
      .rst            (rst),
      .padv_i         (padv_o),
      .load_i         (lsu_load),
      .store_i        (lsu_store),
      .addr_i         (op_a_i),
      .wdata_i        (op_b_i),
      .lsu_valid_o    (lsu_valid),
      .rdata_o        (lsu_rdata),
      .except_dbus_o  (lsu_dbus),
      .except_align_o (lsu_align)
   );

   execute_ctrl i_execute_ctrl (
      .clk                (clk),
      .rst                (rst),
      .padv_i             (padv_o),
      .pipeline_flush_i   (flush_o),
      .opc_i              (opc_i),
      .op_b_i             (op_b_i),
      .pc_i               (pc_i),
      .alu_result_i       (alu_result),
      .lsu_rdata_i        (lsu_rdata),
      .alu_valid_i        (alu_valid),
      .lsu_valid_i        (lsu_valid),
      .flag_set_i         (alu_flag_set),
      .flag_clear_i       (alu_flag_clear),
      .ibus_err_i         (ibus_err_i),
      .illegal_i          (illegal_i),
      .lsu_except_dbus_i  (lsu_dbus),
      .lsu_except_align_i (lsu_align),
      .rf_wb_i            (rf_wb_i),
      .mfspr_we_i         (mfspr_we),
      .epcr_i             (epcr_o),
      .execute_valid_o    (execute_valid),
      .rf_we_o            (rf_we_o),
      .wb_data_o          (wb_data_o),
      .ctrl_result_o      (ctrl_result_o),
      .ctrl_rfb_o         (ctrl_rfb_o),
      .ctrl               (ctrl_if.src)
   );

   except_ctrl i_except_ctrl (
      .clk              (clk),
      .rst              (rst),
      .stall_i          (stall_i),
      .execute_valid_i  (execute_valid),
      .opc_i            (opc_i),
      .ctrl             (ctrl_if.dst),
      .padv_o           (padv_o),
      .pipeline_flush_o (flush_o),
      .mfspr_we_o       (mfspr_we),
      .epcr_o           (epcr_o),
      .except_o         (except_o),
      .ctrl_flag_o      (ctrl_flag_o)
   );

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
   parameter real PERIOD_NS  = 8.0,
   parameter int  RST_CYCLES = 3
   ) (
   output logic clk_o,
   output logic rst_o
   );

   // Free running clock
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   // Reset seen high on the first RST_CYCLES rising edges
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

/* verif/tb_exec_stage.sv */
`timescale 1ns/10ps

`include "exec_params.svh"

module tb_exec_stage
   import exec_pkg::*;
   ();

   localparam int    NUM_INSNS      = 300;
   localparam int    TIMEOUT_CYCLES = NUM_INSNS * (`MUL_CYCLES + 4);
   localparam int    MEM_WORDS      = 1 << `DMEM_AW;
   localparam word_t DMEM_BYTES     = MEM_WORDS * 4;

   logic    clk;
   logic    rst;

   // DUT inputs
   logic    stall;
   opcode_e opc;
   word_t   op_a;
   word_t   op_b;
   word_t   pc;
   logic    ibus_err;
   logic    illegal;
   logic    rf_wb;

   // DUT outputs
   logic    padv;
   logic    rf_we;
   word_t   wb_data;
   word_t   ctrl_result;
   word_t   ctrl_rfb;
   word_t   ctrl_pc;
   opcode_e ctrl_opc;
   logic    ctrl_flag;
   logic    except;
   logic    flush;
   word_t   epcr;

   // Reference model state
   word_t   model_mem [MEM_WORDS];
   logic    model_flag;
   word_t   model_epcr;

   // What the control stage must show after the last accepted insn
   word_t   exp_result;
   word_t   exp_rfb;
   word_t   exp_pc;
   opcode_e exp_opc;
   logic    exp_exc;
   logic    exp_check_result;

   // Outputs at the previous sample point
   word_t   prev_result;
   word_t   prev_rfb;
   word_t   prev_pc;
   opcode_e prev_opc;
   logic    prev_flag;
   logic    prev_padv;
   logic    prev_flush;

   integer  seed = 32'h647fc382;
   int      errors = 0;
   int      accepted = 0;
   int      exceptions = 0;
   int      cycles = 0;
   // Sample points since the last acceptance
   int      since = 15;

   clk_gen i_clk_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   exec_stage_top i_exec_stage_top (
      .clk           (clk),
      .rst           (rst),
      .stall_i       (stall),
      .opc_i         (opc),
      .op_a_i        (op_a),
      .op_b_i        (op_b),
      .pc_i          (pc),
      .ibus_err_i    (ibus_err),
      .illegal_i     (illegal),
      .rf_wb_i       (rf_wb),
      .padv_o        (padv),
      .rf_we_o       (rf_we),
      .wb_data_o     (wb_data),
      .ctrl_result_o (ctrl_result),
      .ctrl_rfb_o    (ctrl_rfb),
      .ctrl_pc_o     (ctrl_pc),
      .ctrl_opc_o    (ctrl_opc),
      .ctrl_flag_o   (ctrl_flag),
      .except_o      (except),
      .flush_o       (flush),
      .epcr_o        (epcr)
   );

   task automatic report_mismatch(input string name, input word_t exp, input word_t act);
      errors++;
      $display("FAIL %s expected %h actual %h (insn %0d, cycle %0d)",
               name, exp, act, accepted, cycles);
   endtask

   task automatic report_event(input string what);
      errors++;
      $display("ERROR %s (insn %0d, cycle %0d)", what, accepted, cycles);
   endtask

   // Draw the next insn and put it on the inputs
   task automatic new_insn();
      word_t     r;
      word_t     r2;
      mem_addr_t idx;
      r  = $random(seed);
      r2 = $random(seed);
      // Extra weight on loads and stores
      case (r[7:5])
         3'd0:    opc = STORE;
         3'd1:    opc = LOAD;
         default: opc = opcode_e'(r[3:0]);
      endcase
      op_a = $random(seed);
      op_b = $random(seed);
      // Equal operands now and then so compares go both ways
      if (r[9:8] == 2'b00)
         op_b = op_a;
      pc       = $random(seed) & 32'hffff_fffc;
      rf_wb    = (r[11:10] != 2'b00);
      ibus_err = 1'b0;
      illegal  = 1'b0;
      // About 1 in 8 insns come with a fetch side error
      if (r[14:12] == 3'd0) begin
         ibus_err = r[15];
         illegal  = !r[15];
      end
      if (opc == JR)
         op_b[1:0] = (r[18:16] == 3'd0) ? {r[19], !r[19]} : 2'b00;
      if ((opc == LOAD) || (opc == STORE)) begin
         // A few hot words so loads often hit earlier stores
         idx = r2[`DMEM_AW-1:0];
         if (r2[6])
            idx = mem_addr_t'(r2[2:0]);
         op_a = word_t'(idx) << 2;
         if ((r2[9:7] == 3'd0) && r2[10])
            op_a[1:0] = {r2[11], !r2[11]};
         else if (r2[9:7] == 3'd0)
            op_a = (r2 | 32'h100) & 32'hffff_fffc;
      end
   endtask

   // Predict what the insn taken on the coming edge does
   task automatic accept_insn();
      logic  lsu_fault;
      logic  exc;
      logic  we;
      word_t res;
      lsu_fault = ((opc == LOAD) || (opc == STORE)) &&
                  ((op_a[1:0] != 2'b00) || (op_a >= DMEM_BYTES));
      exc = ibus_err || illegal || lsu_fault || (opc == SYS) || (opc == TRAP) ||
            ((opc == JR) && (op_b[1:0] != 2'b00));
      case (opc)
         ADD:     res = op_a + op_b;
         SUB:     res = op_a - op_b;
         AND:     res = op_a & op_b;
         OR:      res = op_a | op_b;
         XOR:     res = op_a ^ op_b;
         SHL:     res = op_a << op_b[4:0];
         MUL:     res = op_a * op_b;
         LOAD:    res = model_mem[op_a[`DMEM_AW+1:2]];
         MFSPR:   res = model_epcr;
         default: res = '0;
      endcase
      // Faulting loads and stores never write back, MFSPR always does
      we = (opc == MFSPR) || (rf_wb && !lsu_fault);
      if (rf_we !== we) report_mismatch("rf_we", we, rf_we);
      if (we && (wb_data !== res)) report_mismatch("wb_data", res, wb_data);
      if ((opc == STORE) && !lsu_fault)
         model_mem[op_a[`DMEM_AW+1:2]] = op_b;
      // Flag only moves for compares that retire cleanly
      if (!exc && (opc == SFEQ))
         model_flag = (op_a == op_b);
      if (!exc && (opc == SFNE))
         model_flag = (op_a != op_b);
      if (exc) begin
         model_epcr = pc;
         exceptions++;
      end
      exp_result       = res;
      exp_check_result = !((opc == LOAD) && lsu_fault);
      exp_rfb          = op_b;
      exp_pc           = pc;
      exp_opc          = opc;
      exp_exc          = exc;
      since            = 0;
      accepted++;
   endtask

   // Checks at the sample point of every cycle
   task automatic check_cycle();
      // Control stage only moves on an advance or a flush edge
      if (!prev_padv && !prev_flush) begin
         if (ctrl_result !== prev_result) report_mismatch("hold result", prev_result, ctrl_result);
         if (ctrl_rfb !== prev_rfb) report_mismatch("hold rfb", prev_rfb, ctrl_rfb);
         if (ctrl_pc !== prev_pc) report_mismatch("hold pc", prev_pc, ctrl_pc);
         if (ctrl_opc !== prev_opc) report_mismatch("hold opc", prev_opc, ctrl_opc);
         if (ctrl_flag !== prev_flag) report_mismatch("hold flag", prev_flag, ctrl_flag);
      end
      if (stall && padv) report_event("padv_o high while stall_i is high");
      if (!padv && rf_we) report_event("rf_we_o high without padv_o");
      if (exp_exc && (since inside {1, 2}) && padv)
         report_event("padv_o high with an exception still pending");
      // One flush pulse two edges after the faulting insn
      if (flush !== (exp_exc && (since == 2)))
         report_mismatch("flush pulse", exp_exc && (since == 2), flush);
      if (since == 1) begin
         if (ctrl_opc !== exp_opc) report_mismatch("ctrl_opc", exp_opc, ctrl_opc);
         if (ctrl_pc !== exp_pc) report_mismatch("ctrl_pc", exp_pc, ctrl_pc);
         if (ctrl_rfb !== exp_rfb) report_mismatch("ctrl_rfb", exp_rfb, ctrl_rfb);
         if (exp_check_result && (ctrl_result !== exp_result))
            report_mismatch("ctrl_result", exp_result, ctrl_result);
         if (ctrl_flag !== model_flag) report_mismatch("ctrl_flag", model_flag, ctrl_flag);
         if (except !== exp_exc) report_mismatch("except", exp_exc, except);
      end
      if (exp_exc && (since == 2) && (epcr !== exp_pc))
         report_mismatch("epcr", exp_pc, epcr);
      if (exp_exc && (since == 3)) begin
         if (ctrl_opc !== NOP) report_mismatch("flushed opc", NOP, ctrl_opc);
         if (ctrl_rfb !== '0) report_mismatch("flushed rfb", '0, ctrl_rfb);
         if (ctrl_pc !== `EXC_VECTOR) report_mismatch("flushed pc", `EXC_VECTOR, ctrl_pc);
         if (except !== 1'b0) report_mismatch("except after flush", 1'b0, except);
      end
      prev_result = ctrl_result;
      prev_rfb    = ctrl_rfb;
      prev_pc     = ctrl_pc;
      prev_opc    = ctrl_opc;
      prev_flag   = ctrl_flag;
      prev_padv   = padv;
      prev_flush  = flush;
   endtask

   // Cycle limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run hit the %0d cycle limit after %0d of %0d insns",
                  TIMEOUT_CYCLES, accepted, NUM_INSNS);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      logic took;
      stall    = 1'b0;
      opc      = NOP;
      op_a     = '0;
      op_b     = '0;
      pc       = '0;
      ibus_err = 1'b0;
      illegal  = 1'b0;
      rf_wb    = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
         model_mem[i] = '0;
      model_flag = 1'b0;
      model_epcr = '0;
      exp_exc    = 1'b0;
      prev_padv  = 1'b1;
      prev_flush = 1'b0;

      @(negedge clk);
      while (rst)
         @(negedge clk);
      // Reset values of the control stage
      if (ctrl_pc !== `RESET_PC) report_mismatch("reset ctrl_pc", `RESET_PC, ctrl_pc);
      if (ctrl_opc !== NOP) report_mismatch("reset ctrl_opc", NOP, ctrl_opc);
      if (flush !== 1'b0) report_mismatch("reset flush", 1'b0, flush);
      if (except !== 1'b0) report_mismatch("reset except", 1'b0, except);
      if (rf_we !== 1'b0) report_mismatch("reset rf_we", 1'b0, rf_we);
      if (ctrl_flag !== 1'b0) report_mismatch("reset flag", 1'b0, ctrl_flag);

      new_insn();
      // Run on until the last insn has been through its checks
      while ((accepted < NUM_INSNS) || (since < 4)) begin
         stall = (($random(seed) & 7) == 0);
         #2;
         check_cycle();
         took = padv;
         if (took)
            accept_insn();
         @(negedge clk);
         if (since < 15)
            since = since + 1;
         if (took)
            new_insn();
      end

      $display("errors %0d, insns %0d, exceptions %0d, cycles %0d",
               errors, accepted, exceptions, cycles);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+common
common/exec_pkg.sv
common/ctrl_stage_if.sv
execute/execute_alu.sv
execute/execute_lsu.sv
execute/execute_ctrl.sv
hdl/except_ctrl.sv
hdl/exec_stage_top.sv
verif/clk_gen.sv
verif/tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - common/ctrl_stage_if.sv
      - execute/execute_alu.sv
      - execute/execute_lsu.sv
      - execute/execute_ctrl.sv
      - hdl/except_ctrl.sv
      - hdl/exec_stage_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/clk_gen.sv
      - verif/tb_exec_stage.sv
